// ==== tb.f ====
logic/icache_pkg.sv
logic/icache_tag.sv
logic/icache_data.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verif/mem_model.sv
verif/tb_icache.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_icache -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vtb_icache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verif/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache
  import icache_pkg::*;
();

  localparam int CLK_PERIOD    = 4;
  localparam int MAX_GAP       = 5;
  localparam int NUM_FETCHES   = 24;                        // upper bound over all tests
  localparam int REFILL_CYCLES = BEATS * (MAX_GAP + 1) + 16; // worst refill plus margin
  localparam int TIMEOUT_NS    = NUM_FETCHES * REFILL_CYCLES * CLK_PERIOD;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] fetch_addr;
  logic              fetch_valid;
  logic [XLEN-1:0]   fetch_rdata;
  logic              fetch_rdata_valid;
  logic [ADDR_W-1:0] mem_raddr;
  logic              mem_raddr_valid;
  logic              mem_ready;
  logic [XLEN-1:0]   mem_rdata;
  logic [2:0]        gap_max;
  int unsigned       req_count;
  logic              align_err;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  icache_top i_dut (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr),
    .fetch_valid_i       (fetch_valid),
    .mem_rdata_ready_i   (mem_ready),
    .mem_rdata_i         (mem_rdata),
    .fetch_rdata_o       (fetch_rdata),
    .fetch_rdata_valid_o (fetch_rdata_valid),
    .mem_raddr_o         (mem_raddr),
    .mem_raddr_valid_o   (mem_raddr_valid)
  );

  mem_model u_mem (
    .clk           (clk),
    .rst           (rst),
    .raddr_i       (mem_raddr),
    .raddr_valid_i (mem_raddr_valid),
    .gap_max_i     (gap_max),
    .rdata_ready_o (mem_ready),
    .rdata_o       (mem_rdata),
    .req_count_o   (req_count),
    .align_err_o   (align_err)
  );

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // word address in the upper half, its complement in the lower half
  function automatic logic [XLEN-1:0] expected_word(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] word_addr;
    word_addr = {addr[ADDR_W-1:3], 3'b000};
    return {word_addr, ~word_addr};
  endfunction

  // called on a falling edge, returns on one
  task automatic apply_reset();
    rst         = 1'b1;
    fetch_valid = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic fetch_word(input string name, input logic [ADDR_W-1:0] addr,
                            output logic [XLEN-1:0] data);
    fetch_addr  = addr;
    fetch_valid = 1'b1;
    do begin
      @(negedge clk);
      if (!fetch_rdata_valid) begin
        compare_value({name, " idle data"}, '0, fetch_rdata);  // zero until valid
      end
    end while (!fetch_rdata_valid);  // watchdog bounds this
    data        = fetch_rdata;
    fetch_valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic fetch_and_check(input string name, input logic [ADDR_W-1:0] addr);
    logic [XLEN-1:0] data;
    fetch_word(name, addr, data);
    compare_value(name, expected_word(addr), data);
  endtask

  task automatic cold_miss();
    int unsigned cnt0;
    cnt0 = req_count;
    fetch_and_check("cold_miss data", 32'h0000_1238);
    compare_value("cold_miss requests", XLEN'(cnt0 + 1), XLEN'(req_count));
  endtask

  task automatic hit_whole_line();
    int unsigned cnt0;
    cnt0 = req_count;
    for (int w = 0; w < BEATS; w++) begin
      fetch_and_check("hit_whole_line data", 32'h0000_1200 + ADDR_W'(w * 8));
    end
    compare_value("hit_whole_line requests", XLEN'(cnt0), XLEN'(req_count));
  endtask

  // 0x2238 shares index 8 with 0x1238
  task automatic index_conflict();
    int unsigned cnt0;
    cnt0 = req_count;
    fetch_and_check("index_conflict new tag", 32'h0000_2238);
    compare_value("index_conflict requests", XLEN'(cnt0 + 1), XLEN'(req_count));
    fetch_and_check("index_conflict old tag", 32'h0000_1238);
    compare_value("index_conflict refetch", XLEN'(cnt0 + 2), XLEN'(req_count));
  endtask

  task automatic miss_under_backpressure();
    int unsigned       cnt0;
    logic [ADDR_W-1:0] addr;
    gap_max = 3'(MAX_GAP);
    cnt0    = req_count;
    for (int i = 0; i < 6; i++) begin
      addr = 32'h0008_0000 + ADDR_W'(i) * 32'h0000_00c8;  // index +3, offset +8
      fetch_and_check("miss_under_backpressure data", addr);
    end
    compare_value("miss_under_backpressure requests", XLEN'(cnt0 + 6), XLEN'(req_count));
  endtask

  task automatic reset_invalidation();
    int unsigned cnt0;
    apply_reset();
    cnt0 = req_count;
    fetch_and_check("reset_invalidation data", 32'h0000_1238);
    compare_value("reset_invalidation requests", XLEN'(cnt0 + 1), XLEN'(req_count));
  endtask

  initial begin
    rst         = 1'b1;
    fetch_addr  = '0;
    fetch_valid = 1'b0;
    gap_max     = 3'd0;
    apply_reset();
    cold_miss();
    hit_whole_line();
    index_conflict();
    miss_under_backpressure();
    reset_invalidation();
    $display("SIMULATION PASSED");
    $finish;
  end

  always @(posedge clk) begin
    if (align_err) begin
      $display("memory request address is not line aligned");
      abort_run();
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns", TIMEOUT_NS);
    abort_run();
  end

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/1ps

module mem_model
  import icache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] raddr_i,
  input  logic              raddr_valid_i,
  input  logic [2:0]        gap_max_i,
  output logic              rdata_ready_o,
  output logic [XLEN-1:0]   rdata_o,
  output int unsigned       req_count_o,
  output logic              align_err_o
);

  localparam int unsigned SEED = 24;

  // ready gaps are drawn in the same process that seeds the generator
  initial begin
    int unsigned       beat;
    int unsigned       gap_left;
    logic              valid_seen;
    logic [ADDR_W-1:0] word_addr;
    void'($urandom(SEED));
    rdata_ready_o = 1'b0;
    rdata_o       = '0;
    req_count_o   = 0;
    align_err_o   = 1'b0;
    beat          = 0;
    gap_left      = 0;
    valid_seen    = 1'b0;
    forever begin
      @(negedge clk);
      if (rst) begin
        rdata_ready_o = 1'b0;
        valid_seen    = 1'b0;
      end else begin
        if (rdata_ready_o) begin  // beat taken at the last rising edge
          beat     = beat + 1;
          gap_left = $urandom % (32'(gap_max_i) + 1);
        end
        if (raddr_valid_i && !valid_seen) begin  // new burst
          req_count_o = req_count_o + 1;
          if (raddr_i[OFFSET_W-1:0] != '0) begin
            align_err_o = 1'b1;
          end
          beat     = 0;
          gap_left = $urandom % (32'(gap_max_i) + 1);
        end
        valid_seen = raddr_valid_i;
        if (raddr_valid_i && beat < BEATS && gap_left == 0) begin
          word_addr     = raddr_i + ADDR_W'(beat * 8);
          rdata_ready_o = 1'b1;
          rdata_o       = {word_addr, ~word_addr};  // address word, complement below
        end else begin
          rdata_ready_o = 1'b0;
          if (gap_left > 0) begin
            gap_left = gap_left - 1;
          end
        end
      end
    end
  end

endmodule

// ==== logic/icache_top.sv ====
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] fetch_addr_i,
  input  logic              fetch_valid_i,
  input  logic              mem_rdata_ready_i,
  input  logic [XLEN-1:0]   mem_rdata_i,
  output logic [XLEN-1:0]   fetch_rdata_o,
  output logic              fetch_rdata_valid_o,
  output logic [ADDR_W-1:0] mem_raddr_o,
  output logic              mem_raddr_valid_o
);

  logic [INDEX_W-1:0] line_index;
  logic [TAG_W-1:0]   line_tag;
  logic [BEAT_W-1:0]  word_sel;
  logic [BEAT_W-1:0]  beat_idx;
  logic               tag_wen;
  logic               beat_wen;
  logic               hit;
  logic [XLEN-1:0]    array_rdata;

  // index and tag straight from the fetch address
  assign line_index = fetch_addr_i[OFFSET_W +: INDEX_W];
  assign line_tag   = fetch_addr_i[ADDR_W-1 -: TAG_W];

  icache_ctrl u_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr_i),
    .fetch_valid_i       (fetch_valid_i),
    .hit_i               (hit),
    .mem_rdata_ready_i   (mem_rdata_ready_i),
    .word_sel_o          (word_sel),
    .tag_wen_o           (tag_wen),
    .beat_wen_o          (beat_wen),
    .beat_idx_o          (beat_idx),
    .fetch_rdata_valid_o (fetch_rdata_valid_o),
    .mem_raddr_o         (mem_raddr_o),
    .mem_raddr_valid_o   (mem_raddr_valid_o)
  );

  icache_tag u_tag (
    .clk       (clk),
    .rst       (rst),
    .index_i   (line_index),
    .tag_i     (line_tag),
    .tag_wen_i (tag_wen),
    .hit_o     (hit)
  );

  icache_data u_data (
    .clk        (clk),
    .index_i    (line_index),
    .word_sel_i (word_sel),
    .beat_wen_i (beat_wen),
    .beat_idx_i (beat_idx),
    .wdata_i    (mem_rdata_i),
    .rdata_o    (array_rdata)
  );

  // zero when not valid
  assign fetch_rdata_o = fetch_rdata_valid_o ? array_rdata : '0;

endmodule

// ==== logic/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl
  import icache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] fetch_addr_i,
  input  logic              fetch_valid_i,
  input  logic              hit_i,
  input  logic              mem_rdata_ready_i,
  output logic [BEAT_W-1:0] word_sel_o,
  output logic              tag_wen_o,
  output logic              beat_wen_o,
  output logic [BEAT_W-1:0] beat_idx_o,
  output logic              fetch_rdata_valid_o,
  output logic [ADDR_W-1:0] mem_raddr_o,
  output logic              mem_raddr_valid_o
);

  icache_state_e     state_q;
  icache_state_e     state_d;
  logic [BEAT_W-1:0] beat_cnt_q;
  logic              rdata_valid_q;
  logic              raddr_valid_q;
  logic [ADDR_W-1:0] raddr_q;
  logic              req_hit;
  logic              req_miss;
  logic              mem_xfer;
  logic              last_beat;

  assign req_hit   = (state_q == ST_IDLE) && fetch_valid_i && hit_i;
  assign req_miss  = (state_q == ST_IDLE) && fetch_valid_i && !hit_i;
  assign mem_xfer  = raddr_valid_q && mem_rdata_ready_i;   // one beat this cycle
  assign last_beat = mem_xfer && (beat_cnt_q == BEAT_W'(BEATS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RST: begin
        state_d = ST_IDLE;
      end
      ST_IDLE: begin
        if (req_miss) begin
          state_d = ST_MISS;
        end
      end
      ST_MISS: begin
        // ready gaps from memory just keep us here longer
        if (last_beat) begin
          state_d = ST_FILL_DONE;
        end
      end
      ST_FILL_DONE: begin
        state_d = ST_IDLE;  // request is replayed and hits
      end
      default: begin
        state_d = ST_RST;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= ST_RST;
      rdata_valid_q <= 1'b0;
      raddr_valid_q <= 1'b0;
      beat_cnt_q    <= '0;
    end else begin
      state_q       <= state_d;
      rdata_valid_q <= req_hit;  // single cycle pulse
      if (req_miss) begin
        raddr_valid_q <= 1'b1;
        beat_cnt_q    <= '0;
      end else if (mem_xfer) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        if (last_beat) begin
          raddr_valid_q <= 1'b0;
        end
      end
    end
  end

  // line aligned burst address
  always_ff @(posedge clk) begin
    if (req_miss) begin
      raddr_q <= {fetch_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end
  end

  // word select goes straight to the data array, which registers it with the read
  assign word_sel_o          = fetch_addr_i[OFFSET_W-1 -: BEAT_W];
  assign tag_wen_o           = (state_q == ST_FILL_DONE);
  assign beat_wen_o          = mem_xfer;
  assign beat_idx_o          = beat_cnt_q;
  assign fetch_rdata_valid_o = rdata_valid_q;
  assign mem_raddr_o         = raddr_q;
  assign mem_raddr_valid_o   = raddr_valid_q;

  a_raddr_stable : assert property (
    @(posedge clk) disable iff (rst)
    mem_raddr_valid_o |=> !mem_raddr_valid_o || $stable(mem_raddr_o)
  ) else $error("memory address changed during burst");

  // data array writes belong to an open burst in ST_MISS
  a_beat_in_burst : assert property (
    @(posedge clk) disable iff (rst)
    beat_wen_o |-> mem_raddr_valid_o && (state_q == ST_MISS)
  ) else $error("beat write outside of refill");

  a_no_hit_during_refill : assert property (
    @(posedge clk) disable iff (rst)
    !(fetch_rdata_valid_o && mem_raddr_valid_o)
  ) else $error("fetch data returned while refill is pending");

endmodule

// ==== logic/icache_data.sv ====
`timescale 1ns/1ps

module icache_data
  import icache_pkg::*;
(
  input  logic               clk,
  input  logic [INDEX_W-1:0] index_i,
  input  logic [BEAT_W-1:0]  word_sel_i,
  input  logic               beat_wen_i,
  input  logic [BEAT_W-1:0]  beat_idx_i,
  input  logic [XLEN-1:0]    wdata_i,
  output logic [XLEN-1:0]    rdata_o
);

  // 64 lines x 8 words of 64 bits
  logic [XLEN-1:0] line_mem [NUM_LINES][BEATS];
  logic [XLEN-1:0] rdata_q;

  // refill writes one beat per transfer, in burst order
  always_ff @(posedge clk) begin
    if (beat_wen_i) begin
      line_mem[index_i][beat_idx_i] <= wdata_i;
    end
  end

  // registered read gives the one cycle hit latency
  always_ff @(posedge clk) begin
    rdata_q <= line_mem[index_i][word_sel_i];
  end

  assign rdata_o = rdata_q;

endmodule

// ==== logic/icache_tag.sv ====
`timescale 1ns/1ps

module icache_tag
  import icache_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [INDEX_W-1:0] index_i,
  input  logic [TAG_W-1:0]   tag_i,
  input  logic               tag_wen_i,
  output logic               hit_o
);

  logic [TAG_W-1:0]     tag_mem [NUM_LINES];
  logic [NUM_LINES-1:0] valid_q;

  // valid bits are cleared on reset, so a stale tag can never hit
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_wen_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wen_i) begin
      tag_mem[index_i] <= tag_i;
    end
  end

  // combinational lookup, same cycle as the request
  assign hit_o = valid_q[index_i] && (tag_mem[index_i] == tag_i);

  // the controller sits in ST_RST during reset and must not fill a line
  a_no_tag_write_in_reset : assert property (
    @(posedge clk) rst |-> !tag_wen_i
  ) else $error("tag write while in reset");

endmodule

// ==== logic/icache_pkg.sv ====
package icache_pkg;

  // fetch and memory address width
  localparam int ADDR_W = 32;

  // one instruction word, also one memory beat
  localparam int XLEN = 64;

  // address split: tag | index | byte offset
  localparam int OFFSET_W = 6;                          // 64 byte lines
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W; // 20 bits

  localparam int NUM_LINES = 1 << INDEX_W;              // 64 lines, 4 KB total

  // a refill is a full line of 64-bit beats
  localparam int BEATS  = (1 << OFFSET_W) / (XLEN / 8); // 8 beats
  localparam int BEAT_W = $clog2(BEATS);                // also the word select width

  // controller states
  typedef enum logic [2:0] {
    ST_RST       = 3'd0,
    ST_IDLE      = 3'd1,
    ST_MISS      = 3'd2,  // burst in flight
    ST_FILL_DONE = 3'd3   // line complete, tag written here
  } icache_state_e;

endpackage
